// File: build.f
wtc_pkg.sv
wtc_write_buffer.sv
wtc_write_channel.sv
wtc_read_channel.sv
wtc_line_store.sv
wtc_ctrl.sv
wtc_top.sv
tb_wtc_mem.sv
tb_wtc.sv

// File: Makefile
RTL = wtc_pkg.sv wtc_write_buffer.sv wtc_write_channel.sv wtc_read_channel.sv \
      wtc_line_store.sv wtc_ctrl.sv wtc_top.sv

.PHONY: all lint clean

# build, run, then decide on the log
all: obj_dir/Vtb_wtc
	./obj_dir/Vtb_wtc | tee run.log
	grep -q "RESULT: PASS" run.log

obj_dir/Vtb_wtc: build.f $(RTL) tb_wtc_mem.sv tb_wtc.sv
	verilator --binary --timing --top-module tb_wtc -f build.f -o Vtb_wtc

lint:
	verilator --lint-only -Wall --top-module wtc_top $(RTL)

clean:
	rm -rf obj_dir run.log

// File: tb_wtc.sv
`timescale 1ns/1ns

module tb_wtc;

   // about four times the cycles the tests need
   localparam int MAX_CYCLES = 20000;

   logic        clk_i;
   logic        arst_i;
   logic        req_i;
   logic        we_i;
   logic [15:0] addr_i;
   logic [31:0] wdata_i;
   logic [3:0]  wstrb_i;
   logic        ack_o;
   logic [31:0] rdata_o;
   logic        be_wvalid_o;
   logic [15:0] be_waddr_o;
   logic [63:0] be_wdata_o;
   logic [7:0]  be_wstrb_o;
   logic        be_wready_i;
   logic        be_rvalid_o;
   logic [15:0] be_raddr_o;
   logic [63:0] be_rdata_i;
   logic        be_rready_i;
   logic        wr_hold;

   logic [7:0]  ref_mem [65536];
   logic [15:0] exp_waddr_q [$];
   logic [63:0] exp_wdata_q [$];
   logic [7:0]  exp_wstrb_q [$];
   logic [15:0] raddr_log [$];
   logic [15:0] exp_a;
   logic [63:0] exp_d;
   logic [7:0]  exp_s;
   logic [31:0] rnd;
   int          errors;
   int          wr_errors;
   int          tests;
   int          cycles;
   int          last_lat;

   wtc_top UUT (.*);

   tb_wtc_mem u_mem (
      .clk_i       (clk_i),
      .wr_hold_i   (wr_hold),
      .be_wvalid_i (be_wvalid_o),
      .be_waddr_i  (be_waddr_o),
      .be_wdata_i  (be_wdata_o),
      .be_wstrb_i  (be_wstrb_o),
      .be_wready_o (be_wready_i),
      .be_rvalid_i (be_rvalid_o),
      .be_raddr_i  (be_raddr_o),
      .be_rdata_o  (be_rdata_i),
      .be_rready_o (be_rready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, the cache stopped answering", cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // backend traffic sampled mid-cycle where valid and ready are stable
   always @(negedge clk_i) begin
      if (be_wvalid_o && be_wready_i) begin
         if (exp_waddr_q.size() == 0) begin
            $display("backend write at time %0t to %h was never issued", $time, be_waddr_o);
            wr_errors++;
         end else begin
            exp_a = exp_waddr_q.pop_front();
            exp_d = exp_wdata_q.pop_front();
            exp_s = exp_wstrb_q.pop_front();
            if (be_waddr_o !== exp_a || be_wdata_o !== exp_d || be_wstrb_o !== exp_s) begin
               $display("Error: %0t backend write expected %h %h %h got %h %h %h", $time,
                        exp_a, exp_d, exp_s, be_waddr_o, be_wdata_o, be_wstrb_o);
               wr_errors++;
            end
         end
      end
      if (be_rvalid_o && be_rready_i) raddr_log.push_back(be_raddr_o);
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [7:0] initial_byte(input logic [15:0] a);
      logic [31:0] w;
      w = {2{{2'b00, a[15:2]} ^ 16'hA5C3}};
      return w[a[1:0] * 8 +: 8];
   endfunction

   function automatic logic [31:0] model_word(input logic [15:0] a);
      return {ref_mem[{a[15:2], 2'd3}], ref_mem[{a[15:2], 2'd2}],
              ref_mem[{a[15:2], 2'd1}], ref_mem[{a[15:2], 2'd0}]};
   endfunction

   function automatic int total_errors();
      return errors + wr_errors;
   endfunction

   task automatic report_mismatch(input logic [15:0] a, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("Error: %0t addr %h expected %h got %h", $time, a, exp, got);
      errors++;
   endtask

   task automatic report_beats(input int exp, input int got);
      $display("Error: %0t expected %0d fill beats got %0d", $time, exp, got);
      errors++;
   endtask

   task automatic end_test(input string name, input int err0);
      tests++;
      $display("test %0d %s finished with %0d errors", tests, name, total_errors() - err0);
   endtask

   task automatic complete_handshake(output logic [31:0] data);
      int lat;
      lat = 0;
      while (!ack_o) begin
         @(posedge clk_i);
         #2;
         lat++;
      end
      last_lat = lat;
      data     = rdata_o;
      req_i    = 1'b0;
      while (ack_o) begin
         @(posedge clk_i);
         #2;
      end
   endtask

   task automatic cache_read(input logic [15:0] a, output logic [31:0] data);
      @(posedge clk_i);
      #2;
      req_i  = 1'b1;
      we_i   = 1'b0;
      addr_i = a;
      complete_handshake(data);
   endtask

   task automatic cache_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
      logic [31:0] ignored;
      exp_waddr_q.push_back({a[15:3], 3'b000});
      exp_wdata_q.push_back({d, d});
      exp_wstrb_q.push_back(a[2] ? {s, 4'h0} : {4'h0, s}); // upper lane for bit 2
      for (int b = 0; b < 4; b++) begin
         if (s[b]) ref_mem[{a[15:2], 2'(b)}] = d[b*8 +: 8];
      end
      @(posedge clk_i);
      #2;
      req_i   = 1'b1;
      we_i    = 1'b1;
      addr_i  = a;
      wdata_i = d;
      wstrb_i = s;
      complete_handshake(ignored);
   endtask

   task automatic wait_drain();
      while (exp_waddr_q.size() != 0 || be_wvalid_o) begin
         @(posedge clk_i);
         #2;
      end
   endtask

   task automatic reset_and_first_fill();
      int          err0;
      int          beats0;
      logic [31:0] got;
      err0 = total_errors();
      for (int c = 0; c < 20; c++) begin
         @(posedge clk_i);
         #2;
         if (c == 15) arst_i = 1'b0; // 16 cycles in reset
         if (ack_o || be_wvalid_o || be_rvalid_o) begin
            $display("Error: %0t outputs active around reset", $time);
            errors++;
         end
      end
      beats0 = raddr_log.size();
      cache_read(16'h0124, got);
      if (got !== model_word(16'h0124)) report_mismatch(16'h0124, model_word(16'h0124), got);
      if (raddr_log.size() - beats0 != 2) begin
         report_beats(2, raddr_log.size() - beats0);
      end else if (raddr_log[beats0] !== 16'h0120 || raddr_log[beats0 + 1] !== 16'h0128) begin
         $display("Error: %0t fill addresses %h %h", $time, raddr_log[beats0],
                  raddr_log[beats0 + 1]);
         errors++;
      end
      end_test("reset state", err0);
   endtask

   task automatic hits_after_miss();
      int          err0;
      int          beats0;
      logic [15:0] a;
      logic [31:0] got;
      err0   = total_errors();
      beats0 = 0;
      for (int i = 0; i < 4; i++) begin
         a = 16'h0300 + 16'(4 * i);
         cache_read(a, got);
         if (got !== model_word(a)) report_mismatch(a, model_word(a), got);
         if (i > 0 && last_lat != 3) begin
            $display("Error: %0t hit at %h took %0d cycles, expected 3", $time, a, last_lat);
            errors++;
         end
         if (i == 0) beats0 = raddr_log.size(); // line now cached
      end
      if (raddr_log.size() != beats0) report_beats(0, raddr_log.size() - beats0);
      end_test("hit after miss", err0);
   endtask

   task automatic write_lanes();
      int         err0;
      logic [3:0] strb [6];
      err0 = total_errors();
      strb = '{4'hF, 4'h1, 4'h6, 4'h8, 4'hC, 4'h3};
      for (int i = 0; i < 6; i++) begin
         cache_write(16'h0400 + 16'(4 * i), 32'hC0DE_0000 + 32'(i), strb[i]);
      end
      cache_write(16'h0128, 32'h0BAD_F00D, 4'h9); // hit on the line from the first read
      wait_drain();
      end_test("lane placement", err0);
   endtask

   task automatic partial_writes();
      int          err0;
      int          beats0;
      logic [31:0] got;
      err0 = total_errors();
      cache_read(16'h0500, got);
      if (got !== model_word(16'h0500)) report_mismatch(16'h0500, model_word(16'h0500), got);
      beats0 = raddr_log.size();
      cache_write(16'h0504, 32'h1122_3344, 4'b0101);
      cache_read(16'h0504, got);
      if (got !== model_word(16'h0504)) report_mismatch(16'h0504, model_word(16'h0504), got);
      if (raddr_log.size() != beats0) report_beats(0, raddr_log.size() - beats0);
      cache_write(16'h0618, 32'h5566_7788, 4'b1010); // index 1 never filled
      beats0 = raddr_log.size();
      cache_read(16'h0618, got);
      if (got !== model_word(16'h0618)) report_mismatch(16'h0618, model_word(16'h0618), got);
      if (raddr_log.size() - beats0 != 2) report_beats(2, raddr_log.size() - beats0);
      wait_drain();
      end_test("partial writes", err0);
   endtask

   task automatic write_back_pressure();
      int          err0;
      logic [15:0] a;
      logic [31:0] got;
      err0    = total_errors();
      wr_hold = 1'b1;
      for (int i = 0; i < 8; i++) begin
         a = 16'h0700 + 16'(4 * (i % 3));
         if (i == 5) begin
            // channel and four buffer entries are taken
            fork
               cache_write(a, 32'hBEEF_0000 + 32'(i), 4'hF);
               begin
                  repeat (12) @(posedge clk_i);
                  #2;
                  wr_hold = 1'b0;
               end
            join
            if (last_lat <= 3) begin
               $display("write into a full buffer was acknowledged without waiting");
               errors++;
            end
         end else begin
            cache_write(a, 32'hBEEF_0000 + 32'(i), 4'hF);
            if (i < 5 && last_lat != 3) begin
               $display("Error: %0t write to %h took %0d cycles, expected 3", $time, a, last_lat);
               errors++;
            end
         end
      end
      cache_read(16'h0704, got); // miss behind the pending writes
      if (got !== model_word(16'h0704)) report_mismatch(16'h0704, model_word(16'h0704), got);
      wait_drain();
      end_test("back pressure", err0);
   endtask

   task automatic random_mix();
      int          err0;
      logic [15:0] a;
      logic [3:0]  s;
      logic        we;
      logic [31:0] got;
      err0 = total_errors();
      for (int n = 0; n < 200; n++) begin
         rnd = xorshift(rnd);
         a   = {4'h0, rnd[11:2], 2'b00}; // within 4 KB
         s   = rnd[15:12];
         we  = rnd[16];
         if (s == 4'h0) s = 4'hF;
         rnd = xorshift(rnd);
         if (we) begin
            cache_write(a, rnd, s);
         end else begin
            cache_read(a, got);
            if (got !== model_word(a)) report_mismatch(a, model_word(a), got);
         end
      end
      wait_drain();
      end_test("random mix", err0);
   endtask

   initial begin
      arst_i    = 1'b1;
      req_i     = 1'b0;
      we_i      = 1'b0;
      addr_i    = '0;
      wdata_i   = '0;
      wstrb_i   = '0;
      wr_hold   = 1'b0;
      errors    = 0;
      wr_errors = 0;
      tests     = 0;
      last_lat  = 0;
      rnd       = 32'd34995;
      for (int i = 0; i < 65536; i++) ref_mem[i] = initial_byte(16'(i));
      reset_and_first_fill();
      hits_after_miss();
      write_lanes();
      partial_writes();
      write_back_pressure();
      random_mix();
      $display("tests %0d, errors %0d", tests, total_errors());
      if (total_errors() == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: tb_wtc_mem.sv
`timescale 1ns/1ns

module tb_wtc_mem (
   input  logic        clk_i,
   input  logic        wr_hold_i,
   input  logic        be_wvalid_i,
   input  logic [15:0] be_waddr_i,
   input  logic [63:0] be_wdata_i,
   input  logic [7:0]  be_wstrb_i,
   output logic        be_wready_o,
   input  logic        be_rvalid_i,
   input  logic [15:0] be_raddr_i,
   output logic [63:0] be_rdata_o,
   output logic        be_rready_o
);

   logic [63:0] mem [8192];
   logic [63:0] merged;
   logic [31:0] rnd;
   logic        wready_q;
   logic        rready_q;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // each 32-bit word holds its word address xor a5c3 in both halves
   initial begin
      logic [15:0] v_lo;
      logic [15:0] v_hi;
      for (int i = 0; i < 8192; i++) begin
         v_lo = 16'(2 * i) ^ 16'hA5C3;
         v_hi = 16'(2 * i + 1) ^ 16'hA5C3;
         mem[i] = {v_hi, v_hi, v_lo, v_lo};
      end
      rnd      = 32'd34995;
      wready_q = 1'b0;
      rready_q = 1'b0;
   end

   // stall when the low two bits of a draw are zero
   always @(posedge clk_i) begin
      #2;
      rnd      = xorshift(rnd);
      wready_q = (rnd[1:0] != 2'b00);
      rnd      = xorshift(rnd);
      rready_q = (rnd[1:0] != 2'b00);
   end

   assign be_wready_o = wready_q && !wr_hold_i;
   assign be_rready_o = rready_q && be_rvalid_i;
   assign be_rdata_o  = mem[be_raddr_i[15:3]];

   always @(posedge clk_i) begin
      if (be_wvalid_i && be_wready_o) begin
         merged = mem[be_waddr_i[15:3]];
         for (int b = 0; b < 8; b++) begin
            if (be_wstrb_i[b]) merged[b*8 +: 8] = be_wdata_i[b*8 +: 8]; // byte lanes
         end
         mem[be_waddr_i[15:3]] <= merged;
      end
   end

endmodule

// File: wtc_top.sv
`timescale 1ns/1ns

module wtc_top (
   input  logic                           clk_i,
   input  logic                           arst_i,

   // four-phase front end
   input  logic                           req_i,
   input  logic                           we_i,
   input  logic [wtc_pkg::ADDR_W-1:0]     addr_i,
   input  logic [wtc_pkg::DATA_W-1:0]     wdata_i,
   input  logic [wtc_pkg::NBYTES-1:0]     wstrb_i,
   output logic                           ack_o,
   output logic [wtc_pkg::DATA_W-1:0]     rdata_o,

   // backend write port
   output logic                           be_wvalid_o,
   output logic [wtc_pkg::ADDR_W-1:0]     be_waddr_o,
   output logic [wtc_pkg::BE_DATA_W-1:0]  be_wdata_o,
   output logic [wtc_pkg::BE_NBYTES-1:0]  be_wstrb_o,
   input  logic                           be_wready_i,

   // backend read port
   output logic                           be_rvalid_o,
   output logic [wtc_pkg::ADDR_W-1:0]     be_raddr_o,
   input  logic [wtc_pkg::BE_DATA_W-1:0]  be_rdata_i,
   input  logic                           be_rready_i
);

   logic                            hit;
   logic [wtc_pkg::DATA_W-1:0]      store_rdata;
   logic                            store_wr_en;
   logic                            buf_push;
   logic                            buf_full;
   logic                            buf_empty;
   logic                            buf_pop;
   logic [wtc_pkg::ADDR_W-1:0]      buf_addr;
   logic [wtc_pkg::NBYTES-1:0]      buf_wstrb;
   logic [wtc_pkg::DATA_W-1:0]      buf_wdata;
   logic                            wch_idle;
   logic                            fill_start;
   logic                            fill_done;
   logic                            fill_we;
   logic [wtc_pkg::BEAT_W-1:0]      fill_beat;
   logic [wtc_pkg::BE_DATA_W-1:0]   fill_data;

   wtc_ctrl u_ctrl (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .req_i         (req_i),
      .we_i          (we_i),
      .ack_o         (ack_o),
      .rdata_o       (rdata_o),
      .hit_i         (hit),
      .store_rdata_i (store_rdata),
      .store_wr_en_o (store_wr_en),
      .buf_push_o    (buf_push),
      .buf_full_i    (buf_full),
      .buf_empty_i   (buf_empty),
      .wch_idle_i    (wch_idle),
      .fill_start_o  (fill_start),
      .fill_done_i   (fill_done)
   );

   wtc_write_buffer u_wbuf (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .push_i       (buf_push),
      .push_addr_i  (addr_i),
      .push_wstrb_i (wstrb_i),
      .push_wdata_i (wdata_i),
      .full_o       (buf_full),
      .empty_o      (buf_empty),
      .pop_i        (buf_pop),
      .pop_addr_o   (buf_addr),
      .pop_wstrb_o  (buf_wstrb),
      .pop_wdata_o  (buf_wdata)
   );

   wtc_write_channel u_wch (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .valid_i     (~buf_empty),
      .addr_i      (buf_addr),
      .wstrb_i     (buf_wstrb),
      .wdata_i     (buf_wdata),
      .pop_o       (buf_pop),
      .idle_o      (wch_idle),
      .be_wvalid_o (be_wvalid_o),
      .be_waddr_o  (be_waddr_o),
      .be_wdata_o  (be_wdata_o),
      .be_wstrb_o  (be_wstrb_o),
      .be_wready_i (be_wready_i)
   );

   wtc_read_channel u_rch (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .start_i     (fill_start),
      .line_addr_i (addr_i[wtc_pkg::ADDR_W-1:wtc_pkg::INDEX_LSB]),
      .be_rvalid_o (be_rvalid_o),
      .be_raddr_o  (be_raddr_o),
      .be_rdata_i  (be_rdata_i),
      .be_rready_i (be_rready_i),
      .fill_we_o   (fill_we),
      .fill_beat_o (fill_beat),
      .fill_data_o (fill_data),
      .done_o      (fill_done)
   );

   wtc_line_store u_store (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .index_i     (addr_i[wtc_pkg::INDEX_LSB +: wtc_pkg::INDEX_W]),
      .tag_i       (addr_i[wtc_pkg::TAG_LSB +: wtc_pkg::TAG_W]),
      .word_i      (addr_i[wtc_pkg::NBYTES_W +: wtc_pkg::WORD_OFFSET_W]),
      .hit_o       (hit),
      .rdata_o     (store_rdata),
      .wr_en_i     (store_wr_en),
      .wstrb_i     (wstrb_i),
      .wdata_i     (wdata_i),
      .fill_we_i   (fill_we),
      .fill_beat_i (fill_beat),
      .fill_data_i (fill_data)
   );

endmodule

// File: wtc_ctrl.sv
`timescale 1ns/1ns

module wtc_ctrl (
   input  logic                         clk_i,
   input  logic                         arst_i,

   // front end
   input  logic                         req_i,
   input  logic                         we_i,
   output logic                         ack_o,
   output logic [wtc_pkg::DATA_W-1:0]   rdata_o,

   // line store
   input  logic                         hit_i,
   input  logic [wtc_pkg::DATA_W-1:0]   store_rdata_i,
   output logic                         store_wr_en_o,

   // write path
   output logic                         buf_push_o,
   input  logic                         buf_full_i,
   input  logic                         buf_empty_i,
   input  logic                         wch_idle_i,

   // line fill
   output logic                         fill_start_o,
   input  logic                         fill_done_i
);

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_write_wait,
      st_drain,
      st_fill,
      st_respond,
      st_release
   } state_t;

   state_t state_q;

   logic push_ok;
   logic drained;

   assign push_ok = (state_q == st_write_wait) && !buf_full_i;
   assign drained = buf_empty_i && wch_idle_i; // keeps read after write order

   assign buf_push_o    = push_ok;
   assign store_wr_en_o = push_ok && hit_i;
   assign fill_start_o  = (state_q == st_drain) && drained;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= st_idle;
         ack_o   <= 1'b0;
      end else begin
         case (state_q)
            st_idle:       if (req_i) state_q <= st_lookup;
            st_lookup: begin
               if (we_i) state_q <= st_write_wait;
               else if (hit_i) state_q <= st_respond;
               else state_q <= st_drain;
            end
            st_write_wait: begin
               if (push_ok) begin
                  ack_o   <= 1'b1;
                  state_q <= st_release;
               end
            end
            st_drain:      if (drained) state_q <= st_fill;
            st_fill:       if (fill_done_i) state_q <= st_lookup; // look up again
            st_respond: begin
               ack_o   <= 1'b1;
               state_q <= st_release;
            end
            st_release: begin
               if (!req_i) begin
                  ack_o   <= 1'b0;
                  state_q <= st_idle;
               end
            end
            default:       state_q <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == st_respond) rdata_o <= store_rdata_i;
   end

endmodule

// File: wtc_line_store.sv
`timescale 1ns/1ns

module wtc_line_store (
   input  logic                                 clk_i,
   input  logic                                 arst_i,

   // lookup
   input  logic [wtc_pkg::INDEX_W-1:0]          index_i,
   input  logic [wtc_pkg::TAG_W-1:0]            tag_i,
   input  logic [wtc_pkg::WORD_OFFSET_W-1:0]    word_i,
   output logic                                 hit_o,
   output logic [wtc_pkg::DATA_W-1:0]           rdata_o,

   // word update from a write hit
   input  logic                                 wr_en_i,
   input  logic [wtc_pkg::NBYTES-1:0]           wstrb_i,
   input  logic [wtc_pkg::DATA_W-1:0]           wdata_i,

   // line fill
   input  logic                                 fill_we_i,
   input  logic [wtc_pkg::BEAT_W-1:0]           fill_beat_i,
   input  logic [wtc_pkg::BE_DATA_W-1:0]        fill_data_i
);

   localparam int NLINES = 2 ** wtc_pkg::INDEX_W;

   logic [wtc_pkg::TAG_W-1:0]  tag_mem  [NLINES];
   logic [wtc_pkg::LINE_W-1:0] data_mem [NLINES];
   logic [NLINES-1:0]          valid_q;

   logic [wtc_pkg::LINE_W-1:0] line;
   logic                       last_fill;

   assign line      = data_mem[index_i];
   assign hit_o     = valid_q[index_i] && (tag_mem[index_i] == tag_i);
   assign rdata_o   = line[word_i * wtc_pkg::DATA_W +: wtc_pkg::DATA_W];
   assign last_fill = fill_we_i &&
                      (fill_beat_i == wtc_pkg::BEAT_W'(wtc_pkg::LINE_BEATS - 1));

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         for (int b = 0; b < wtc_pkg::NBYTES; b++) begin
            if (wstrb_i[b]) begin
               data_mem[index_i][word_i * wtc_pkg::DATA_W + b * 8 +: 8] <= wdata_i[b * 8 +: 8];
            end
         end
      end
      if (fill_we_i) begin
         data_mem[index_i][fill_beat_i * wtc_pkg::BE_DATA_W +: wtc_pkg::BE_DATA_W] <= fill_data_i;
      end
      if (last_fill) tag_mem[index_i] <= tag_i;
   end

   // line becomes valid with its last beat
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else if (last_fill) begin
         valid_q[index_i] <= 1'b1;
      end
   end

endmodule

// File: wtc_read_channel.sv
`timescale 1ns/1ns

module wtc_read_channel (
   input  logic                                            clk_i,
   input  logic                                            arst_i,
   input  logic                                            start_i,
   input  logic [wtc_pkg::TAG_W+wtc_pkg::INDEX_W-1:0]      line_addr_i,

   // backend read port
   output logic                                            be_rvalid_o,
   output logic [wtc_pkg::ADDR_W-1:0]                      be_raddr_o,
   input  logic [wtc_pkg::BE_DATA_W-1:0]                   be_rdata_i,
   input  logic                                            be_rready_i,

   // fill towards the line store
   output logic                                            fill_we_o,
   output logic [wtc_pkg::BEAT_W-1:0]                      fill_beat_o,
   output logic [wtc_pkg::BE_DATA_W-1:0]                   fill_data_o,
   output logic                                            done_o
);

   logic                        busy_q;
   logic [wtc_pkg::BEAT_W-1:0]  beat_q;
   logic                        done_q;
   logic                        last_beat;

   assign last_beat = (beat_q == wtc_pkg::BEAT_W'(wtc_pkg::LINE_BEATS - 1));

   // line address is held by the front end for the whole miss
   assign be_rvalid_o = busy_q;
   assign be_raddr_o  = {line_addr_i, beat_q, {wtc_pkg::BE_NBYTES_W{1'b0}}};

   assign fill_we_o   = busy_q & be_rready_i;
   assign fill_beat_o = beat_q;
   assign fill_data_o = be_rdata_i;
   assign done_o      = done_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_q <= 1'b0;
         beat_q <= '0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (start_i && !busy_q) begin
            busy_q <= 1'b1;
            beat_q <= '0;
         end else if (fill_we_o) begin
            if (last_beat) begin
               busy_q <= 1'b0;
               beat_q <= '0;
               done_q <= 1'b1; // line complete
            end else begin
               beat_q <= beat_q + 1'b1;
            end
         end
      end
   end

endmodule

// File: wtc_write_channel.sv
`timescale 1ns/1ns

module wtc_write_channel (
   input  logic                           clk_i,
   input  logic                           arst_i,

   // buffered write entry
   input  logic                           valid_i,
   input  logic [wtc_pkg::ADDR_W-1:0]     addr_i,
   input  logic [wtc_pkg::NBYTES-1:0]     wstrb_i,
   input  logic [wtc_pkg::DATA_W-1:0]     wdata_i,
   output logic                           pop_o,
   output logic                           idle_o,

   // backend write port
   output logic                           be_wvalid_o,
   output logic [wtc_pkg::ADDR_W-1:0]     be_waddr_o,
   output logic [wtc_pkg::BE_DATA_W-1:0]  be_wdata_o,
   output logic [wtc_pkg::BE_NBYTES-1:0]  be_wstrb_o,
   input  logic                           be_wready_i
);

   localparam int LANE_W = wtc_pkg::BE_NBYTES_W - wtc_pkg::NBYTES_W;

   typedef enum logic {
      st_idle,
      st_write
   } state_t;

   state_t state_q;

   logic [wtc_pkg::ADDR_W-1:0]    addr_q;
   logic [wtc_pkg::NBYTES-1:0]    wstrb_q;
   logic [wtc_pkg::DATA_W-1:0]    wdata_q;
   logic [wtc_pkg::BE_NBYTES-1:0] wstrb_wide;
   logic [LANE_W-1:0]             lane;

   assign idle_o = (state_q == st_idle);
   assign pop_o  = valid_i & idle_o; // take and pop in the same cycle

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= st_idle;
      end else begin
         case (state_q)
            st_idle:  if (valid_i) state_q <= st_write;
            st_write: if (be_wready_i) state_q <= st_idle;
            default:  state_q <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         addr_q  <= addr_i;
         wstrb_q <= wstrb_i;
         wdata_q <= wdata_i;
      end
   end

   assign lane       = addr_q[wtc_pkg::NBYTES_W +: LANE_W];
   assign wstrb_wide = {{(wtc_pkg::BE_NBYTES - wtc_pkg::NBYTES){1'b0}}, wstrb_q};

   assign be_wvalid_o = (state_q == st_write);
   assign be_waddr_o  = {addr_q[wtc_pkg::ADDR_W-1:wtc_pkg::BE_NBYTES_W],
                         {wtc_pkg::BE_NBYTES_W{1'b0}}};
   assign be_wdata_o  = {(wtc_pkg::BE_DATA_W / wtc_pkg::DATA_W){wdata_q}}; // word in every half
   assign be_wstrb_o  = be_wvalid_o ? (wstrb_wide << (lane * wtc_pkg::NBYTES)) : '0;

endmodule

// File: wtc_write_buffer.sv
`timescale 1ns/1ns

module wtc_write_buffer (
   input  logic                         clk_i,
   input  logic                         arst_i,
   input  logic                         push_i,
   input  logic [wtc_pkg::ADDR_W-1:0]   push_addr_i,
   input  logic [wtc_pkg::NBYTES-1:0]   push_wstrb_i,
   input  logic [wtc_pkg::DATA_W-1:0]   push_wdata_i,
   output logic                         full_o,
   output logic                         empty_o,
   input  logic                         pop_i,
   output logic [wtc_pkg::ADDR_W-1:0]   pop_addr_o,
   output logic [wtc_pkg::NBYTES-1:0]   pop_wstrb_o,
   output logic [wtc_pkg::DATA_W-1:0]   pop_wdata_o
);

   logic [wtc_pkg::ADDR_W-1:0] addr_mem  [wtc_pkg::WBUF_DEPTH];
   logic [wtc_pkg::NBYTES-1:0] wstrb_mem [wtc_pkg::WBUF_DEPTH];
   logic [wtc_pkg::DATA_W-1:0] wdata_mem [wtc_pkg::WBUF_DEPTH];

   logic [wtc_pkg::WBUF_PTR_W-1:0] wr_ptr_q;
   logic [wtc_pkg::WBUF_PTR_W-1:0] rd_ptr_q;
   logic [wtc_pkg::WBUF_PTR_W:0]   count_q; // one extra bit for the full case

   assign full_o  = (count_q == (wtc_pkg::WBUF_PTR_W + 1)'(wtc_pkg::WBUF_DEPTH));
   assign empty_o = (count_q == '0);

   // oldest entry shown without read latency
   assign pop_addr_o  = addr_mem[rd_ptr_q];
   assign pop_wstrb_o = wstrb_mem[rd_ptr_q];
   assign pop_wdata_o = wdata_mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         addr_mem[wr_ptr_q]  <= push_addr_i;
         wstrb_mem[wr_ptr_q] <= push_wstrb_i;
         wdata_mem[wr_ptr_q] <= push_wdata_i;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
         if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// File: wtc_pkg.sv
package wtc_pkg;

   // front end
   localparam int ADDR_W   = 16;
   localparam int DATA_W   = 32;
   localparam int NBYTES   = DATA_W / 8;
   localparam int NBYTES_W = 2;

   // backend memory
   localparam int BE_DATA_W   = 64;
   localparam int BE_NBYTES   = BE_DATA_W / 8;
   localparam int BE_NBYTES_W = 3;

   // four words per line
   localparam int WORD_OFFSET_W = 2;
   localparam int LINE_W        = DATA_W * (2 ** WORD_OFFSET_W);
   localparam int LINE_BEATS    = LINE_W / BE_DATA_W;
   localparam int BEAT_W        = 1;
   localparam int INDEX_W       = 4;
   localparam int TAG_W         = ADDR_W - INDEX_W - WORD_OFFSET_W - NBYTES_W;

   // address field positions
   localparam int INDEX_LSB = NBYTES_W + WORD_OFFSET_W;
   localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

   // write buffer
   localparam int WBUF_DEPTH = 4;
   localparam int WBUF_PTR_W = 2;

endpackage
